/* flist.f */
src/rob_pkg.sv
src/rob_entry_store.sv
src/rob_pointers.sv
src/branch_resolver.sv
src/commit_ctrl.sv
src/rob_top.sv
dv/rob_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module rob_tb -f flist.f -o rob_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/rob_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
exit 0

/* dv/rob_tb.sv */
`timescale 1ns/1ps

module rob_tb import rob_pkg::*; ();

  localparam int ROB_ENTRY = 8;
  localparam int NUM_FU = 3;
  localparam int TAG_W = $clog2(ROB_ENTRY);
  localparam int SLOT_W = $clog2(NUM_FU);
  localparam int NUM_TESTS = 6;
  localparam int CLK_PERIOD = 100;

  typedef struct packed {
    issue_entry_t         info;
    logic [NUM_FLAGS-1:0] wflags;
    logic [WORD_W-1:0]    result;
    logic [TAG_W-1:0]     tag;
  } model_t;

  logic                 clk_i;
  logic                 reset_i;
  logic                 issue_valid_i;
  issue_entry_t         issue_entry_i;
  logic [TAG_W-1:0]     rob_tag_o;
  logic                 credit_o;
  logic                 flush_o;
  cdb_t                 cdb [NUM_FU];
  logic [NUM_FLAGS-1:0] flags_i;
  logic                 sb_valid_o;
  logic                 phys_free_valid_o;
  logic [PREG_W-1:0]    phys_free_reg_o;
  logic                 rename_valid_o;
  commit_rename_t       rename_o;
  logic                 flag_valid_o;
  flag_update_t         flag_o;
  logic                 redirect_valid_o;
  logic [WORD_W-1:0]    redirect_pc_o;

  // owned by the stimulus process
  model_t           issued_q [$];
  model_t           pend_q [$];
  int               issued_cnt;
  logic [TAG_W-1:0] alloc_tag;
  logic [31:0]      rng_q;
  logic             mispredict_armed;
  logic [WORD_W-1:0] exp_target;
  string            cur_test;
  int               errors;
  int               test_err_start;
  int               tests_passed;
  int               tests_failed;

  // owned by the commit monitor
  int                commit_idx;
  int                returned_cnt;
  int                flush_count;
  logic              last_redirect;
  logic              exp_flush;
  logic              have_exp;
  logic              exp_store;
  logic              exp_free_v;
  logic [PREG_W-1:0] exp_free_reg;
  commit_rename_t    exp_rename;
  flag_update_t      exp_flag;

  rob_top #(.ROB_ENTRY(ROB_ENTRY), .NUM_FU(NUM_FU)) dut (
    .clk_i(clk_i), .reset_i(reset_i),
    .issue_valid_i(issue_valid_i), .issue_entry_i(issue_entry_i), .rob_tag_o(rob_tag_o),
    .credit_o(credit_o), .flush_o(flush_o),
    .cdb_i(cdb), .flags_i(flags_i),
    .sb_valid_o(sb_valid_o),
    .phys_free_valid_o(phys_free_valid_o), .phys_free_reg_o(phys_free_reg_o),
    .rename_valid_o(rename_valid_o), .rename_o(rename_o),
    .flag_valid_o(flag_valid_o), .flag_o(flag_o),
    .redirect_valid_o(redirect_valid_o), .redirect_pc_o(redirect_pc_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    rng_q = rng_q ^ (rng_q << 13);
    rng_q = rng_q ^ (rng_q >> 17);
    rng_q = rng_q ^ (rng_q << 5);
    return rng_q;
  endfunction

  function automatic int credits_left();
    return ROB_ENTRY - issued_cnt + returned_cnt;
  endfunction

  // odd codes invert the base test of their pair
  function automatic logic cond_holds(input cond_e op, input logic [NUM_FLAGS-1:0] f);
    logic [3:0] code;
    logic       base;
    code = op;
    case (code[3:1])
      3'd0: base = f[z_idx];
      3'd1: base = f[c_idx];
      3'd2: base = f[n_idx];
      3'd3: base = f[v_idx];
      3'd4: base = f[c_idx] && !f[z_idx];
      3'd5: base = (f[n_idx] == f[v_idx]);
      3'd6: base = !f[z_idx] && (f[n_idx] == f[v_idx]);
      default: base = 1'b1;
    endcase
    return base ^ code[0];
  endfunction

  function automatic issue_entry_t plain_entry(input logic [WORD_W-1:0] pc);
    issue_entry_t e;
    logic [31:0]  r;
    r = next_rand();
    e = '0;
    e.pc = pc;
    e.w_v = 1'b1;
    e.alloc_reg = r[5:0];
    e.freed_reg = r[11:6];
    e.bcc_op = AL;
    return e;
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    errors++;
    $display("Mismatch in %s, %s: expected %0h, actual %0h", cur_test, what, exp_v, act_v);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("Error in %s: %s", cur_test, msg);
  endtask

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err_start = errors;
  endtask

  task automatic end_test();
    if (errors == test_err_start)
    begin
      tests_passed++;
      $display("test %s finished without errors", cur_test);
    end
    else
    begin
      tests_failed++;
      $display("test %s finished with %0d errors", cur_test, errors - test_err_start);
    end
  endtask

  task automatic issue(input issue_entry_t e, input logic [NUM_FLAGS-1:0] wflags,
                       input logic [WORD_W-1:0] result);
    model_t m;
    int     waited;
    waited = 0;
    while (credits_left() == 0 && waited < 50)
    begin
      step();
      waited++;
    end
    if (credits_left() == 0)
      report_error("no credit came back for the next issue");
    else
    begin
      m.info = e;
      m.wflags = wflags;
      m.result = result;
      m.tag = alloc_tag;
      issue_valid_i = 1'b1;
      issue_entry_i = e;
      issued_q.push_back(m);
      pend_q.push_back(m);
      issued_cnt++;
      step();
      issue_valid_i = 1'b0;
      alloc_tag = alloc_tag + 1'b1;
    end
  endtask

  task automatic drive_slot(input logic [SLOT_W-1:0] slot, input model_t m);
    cdb[slot].valid = 1'b1;
    cdb[slot].rob_tag = CDB_TAG_W'(m.tag);
    cdb[slot].flags = m.wflags;
    cdb[slot].result = m.result;
  endtask

  task automatic clear_cdb();
    for (int j = 0; j < NUM_FU; j++)
      cdb[j] = '0;
  endtask

  // random write-back order with at most one entry per bus slot each cycle
  task automatic write_back_all();
    int idx;
    while (pend_q.size() > 0)
    begin
      for (int j = 0; j < NUM_FU; j++)
      begin
        if (pend_q.size() > 0 && (next_rand() & 32'd1) != 32'd0)
        begin
          idx = int'(next_rand() % 32'(pend_q.size()));
          drive_slot(SLOT_W'(j), pend_q[idx]);
          pend_q.delete(idx);
        end
      end
      step();
      clear_cdb();
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((commit_idx < issued_q.size() || credits_left() != ROB_ENTRY) && waited < 100)
    begin
      step();
      waited++;
    end
    if (commit_idx < issued_q.size())
      report_error("buffer did not drain");
    else if (credits_left() != ROB_ENTRY)
      report_mismatch("credits", 64'(ROB_ENTRY), 64'(credits_left()));
  endtask

  // issues a speculative branch and the entry that follows it
  task automatic branch_pair(input cond_e op, input logic is_cond, input logic wrong);
    issue_entry_t      b;
    issue_entry_t      n;
    logic [31:0]       r;
    logic [WORD_W-1:0] pc;
    logic [WORD_W-1:0] target;
    logic [WORD_W-1:0] next_pc;
    r = next_rand();
    pc = {16'h0000, r[15:2], 2'b00};
    target = {16'h0001, r[31:18], 2'b00};
    flags_i = NUM_FLAGS'(next_rand());
    b = plain_entry(pc);
    b.w_v = 1'b0;
    b.is_spec = 1'b1;
    b.is_cond_branch = is_cond;
    b.bcc_op = op;
    if (is_cond && !cond_holds(op, flags_i))
      next_pc = pc + 32'd4;
    else
      next_pc = target;
    n = plain_entry(wrong ? next_pc + 32'd8 : next_pc);
    exp_target = next_pc;
    mispredict_armed = wrong;
    issue(b, '0, target);
    issue(n, r[3:0], '0);
  endtask

  always @(negedge clk_i)
  begin
    model_t cur;
    if (reset_i)
    begin
      commit_idx = 0;
      returned_cnt = 0;
      flush_count = 0;
      last_redirect = 1'b0;
      exp_flush = 1'b0;
      have_exp = 1'b0;
    end
    else
    begin
      exp_flush = last_redirect;
      last_redirect = redirect_valid_o;
      have_exp = rename_valid_o && commit_idx < issued_q.size();
      if (have_exp)
      begin
        cur = issued_q[commit_idx];
        commit_idx++;
        exp_rename.w_v = cur.info.w_v;
        exp_rename.alloc_reg = cur.info.alloc_reg;
        exp_rename.freed_reg = cur.info.freed_reg;
        exp_store = cur.info.is_store;
        exp_free_v = cur.info.w_v && !cur.info.is_store;
        exp_free_reg = cur.info.freed_reg;
        exp_flag.mask = cur.info.flag_mask;
        exp_flag.flags = cur.wflags;
      end
      if (credit_o)
        returned_cnt++;
      // everything in flight is dropped and its credits come back
      if (flush_o)
      begin
        commit_idx = issued_q.size();
        returned_cnt = issued_cnt;
        flush_count++;
      end
    end
  end

  a_commit_known: assert property (@(posedge clk_i) disable iff (reset_i)
    rename_valid_o |-> have_exp)
    else report_error("commit pulse with no issued entry left");
  a_rename: assert property (@(posedge clk_i) disable iff (reset_i)
    rename_valid_o |-> rename_o == exp_rename)
    else report_mismatch("rename", 64'(exp_rename), 64'(rename_o));
  a_store: assert property (@(posedge clk_i) disable iff (reset_i)
    sb_valid_o == (rename_valid_o && exp_store))
    else report_mismatch("sb_valid", 64'(rename_valid_o && exp_store), 64'(sb_valid_o));
  a_free_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    phys_free_valid_o == (rename_valid_o && exp_free_v))
    else report_mismatch("phys_free_valid", 64'(rename_valid_o && exp_free_v),
                         64'(phys_free_valid_o));
  a_free_reg: assert property (@(posedge clk_i) disable iff (reset_i)
    phys_free_valid_o |-> phys_free_reg_o == exp_free_reg)
    else report_mismatch("phys_free_reg", 64'(exp_free_reg), 64'(phys_free_reg_o));
  a_flag_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    flag_valid_o == (rename_valid_o && exp_flag.mask != '0))
    else report_mismatch("flag_valid", 64'(rename_valid_o && exp_flag.mask != '0),
                         64'(flag_valid_o));
  a_flag: assert property (@(posedge clk_i) disable iff (reset_i)
    flag_valid_o |-> flag_o == exp_flag)
    else report_mismatch("flag", 64'(exp_flag), 64'(flag_o));
  a_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    credit_o == rename_valid_o)
    else report_mismatch("credit", 64'(rename_valid_o), 64'(credit_o));
  a_credit_range: assert property (@(posedge clk_i) disable iff (reset_i)
    credits_left() >= 0 && credits_left() <= ROB_ENTRY)
    else report_error("credit count out of range");
  a_redirect_expected: assert property (@(posedge clk_i) disable iff (reset_i)
    redirect_valid_o |-> mispredict_armed)
    else report_error("redirect without a mispredicted branch");
  a_redirect_pc: assert property (@(posedge clk_i) disable iff (reset_i)
    redirect_valid_o |-> redirect_pc_o == exp_target)
    else report_mismatch("redirect_pc", 64'(exp_target), 64'(redirect_pc_o));
  a_redirect_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
    redirect_valid_o |-> !rename_valid_o && !sb_valid_o && !flag_valid_o)
    else report_error("commit pulse in the redirect cycle");
  a_flush: assert property (@(posedge clk_i) disable iff (reset_i)
    flush_o == exp_flush)
    else report_mismatch("flush", 64'(exp_flush), 64'(flush_o));
  a_tag: assert property (@(posedge clk_i) disable iff (reset_i)
    issue_valid_i |-> rob_tag_o == alloc_tag)
    else report_mismatch("rob_tag", 64'(alloc_tag), 64'(rob_tag_o));

  initial
  begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("TEST FAIL");
    $finish;
  end

  initial
  begin
    issue_entry_t e;
    logic [31:0]  r;
    int           flush_start;
    int           waited;
    rng_q = 32'hd0d;
    reset_i = 1'b1;
    issue_valid_i = 1'b0;
    issue_entry_i = '0;
    flags_i = '0;
    clear_cdb();
    issued_cnt = 0;
    alloc_tag = '0;
    mispredict_armed = 1'b0;
    exp_target = '0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    cur_test = "reset";
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    start_test("in_order_commit");
    for (int i = 0; i < ROB_ENTRY; i++)
      issue(plain_entry(32'h100 + 32'(4 * i)), '0, '0);
    write_back_all();
    wait_drain();
    end_test();

    start_test("credits");
    for (int i = 0; i < ROB_ENTRY; i++)
      issue(plain_entry(32'h200 + 32'(4 * i)), '0, '0);
    if (credits_left() != 0)
      report_mismatch("credits after burst", 64'd0, 64'(credits_left()));
    write_back_all();
    wait_drain();
    end_test();

    start_test("commit_classes");
    for (int i = 0; i < ROB_ENTRY; i++)
    begin
      r = next_rand();
      e = plain_entry(32'h300 + 32'(4 * i));
      e.is_store = r[0];
      e.w_v = r[1];
      e.flag_mask = r[7:4];
      issue(e, r[11:8], '0);
    end
    write_back_all();
    wait_drain();
    end_test();

    start_test("correct_prediction");
    for (int k = 0; k < 16; k++)
    begin
      branch_pair(cond_e'(4'(k)), 1'b1, 1'b0);
      write_back_all();
      wait_drain();
    end
    // register-target branch
    branch_pair(AL, 1'b0, 1'b0);
    write_back_all();
    wait_drain();
    end_test();

    start_test("mispredict");
    for (int k = 0; k < 3; k++)
    begin
      r = next_rand();
      branch_pair(cond_e'(r[3:0]), 1'b1, 1'b1);
      issue(plain_entry(32'h400), '0, '0);
      // younger entry first so no write lands after the flush
      drive_slot('0, pend_q.pop_back());
      step();
      clear_cdb();
      flush_start = flush_count;
      write_back_all();
      waited = 0;
      while (flush_count == flush_start && waited < 50)
      begin
        step();
        waited++;
      end
      if (flush_count == flush_start)
        report_error("no flush after the mispredicted branch");
      alloc_tag = '0;
      mispredict_armed = 1'b0;
      step();
      if (credits_left() != ROB_ENTRY)
        report_mismatch("credits after flush", 64'(ROB_ENTRY), 64'(credits_left()));
    end
    end_test();

    start_test("recovery");
    for (int i = 0; i < 5; i++)
      issue(plain_entry(32'h500 + 32'(4 * i)), '0, '0);
    write_back_all();
    wait_drain();
    end_test();

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

/* src/rob_top.sv */
`timescale 1ns/1ps

module rob_top import rob_pkg::*;
#(
  parameter int ROB_ENTRY = 8,
  parameter int NUM_FU = 3,
  localparam int TAG_W = $clog2(ROB_ENTRY)
)
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 issue_valid_i,
  input  issue_entry_t         issue_entry_i,
  output logic [TAG_W-1:0]     rob_tag_o,
  output logic                 credit_o,
  output logic                 flush_o,
  input  cdb_t                 cdb_i [NUM_FU],
  input  logic [NUM_FLAGS-1:0] flags_i,
  output logic                 sb_valid_o,
  output logic                 phys_free_valid_o,
  output logic [PREG_W-1:0]    phys_free_reg_o,
  output logic                 rename_valid_o,
  output commit_rename_t       rename_o,
  output logic                 flag_valid_o,
  output flag_update_t         flag_o,
  output logic                 redirect_valid_o,
  output logic [WORD_W-1:0]    redirect_pc_o
);

  rob_entry_t       head_entry;
  logic             mispredict;
  logic             commit_en;
  logic             flush;
  logic [TAG_W-1:0] alloc_ptr;
  logic [TAG_W-1:0] commit_ptr;

  rob_entry_store #(.ROB_ENTRY(ROB_ENTRY), .NUM_FU(NUM_FU)) u_store (
    .clk_i(clk_i), .reset_i(reset_i),
    .issue_we_i(issue_valid_i), .issue_entry_i(issue_entry_i), .alloc_ptr_i(alloc_ptr),
    .cdb_i(cdb_i),
    .commit_en_i(commit_en), .commit_ptr_i(commit_ptr), .flush_i(flush),
    .head_o(head_entry)
  );

  rob_pointers #(.ROB_ENTRY(ROB_ENTRY)) u_ptrs (
    .clk_i(clk_i), .reset_i(reset_i),
    .alloc_i(issue_valid_i), .commit_i(commit_en), .flush_i(flush),
    .alloc_ptr_o(alloc_ptr), .commit_ptr_o(commit_ptr)
  );

  branch_resolver u_branch (
    .clk_i(clk_i), .reset_i(reset_i),
    .head_i(head_entry), .commit_i(commit_en), .flush_i(flush), .flags_i(flags_i),
    .mispredict_o(mispredict), .redirect_pc_o(redirect_pc_o)
  );

  commit_ctrl u_ctrl (
    .clk_i(clk_i), .reset_i(reset_i),
    .head_i(head_entry), .mispredict_i(mispredict),
    .commit_en_o(commit_en), .flush_o(flush), .credit_o(credit_o),
    .sb_valid_o(sb_valid_o),
    .phys_free_valid_o(phys_free_valid_o), .phys_free_reg_o(phys_free_reg_o),
    .rename_valid_o(rename_valid_o), .rename_o(rename_o),
    .flag_valid_o(flag_valid_o), .flag_o(flag_o)
  );

  // the issuing slot is always the allocation pointer
  assign rob_tag_o = alloc_ptr;
  assign flush_o = flush;
  assign redirect_valid_o = mispredict;

endmodule

/* src/commit_ctrl.sv */
`timescale 1ns/1ps

module commit_ctrl import rob_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  input  rob_entry_t        head_i,
  input  logic              mispredict_i,
  output logic              commit_en_o,
  output logic              flush_o,
  output logic              credit_o,
  output logic              sb_valid_o,
  output logic              phys_free_valid_o,
  output logic [PREG_W-1:0] phys_free_reg_o,
  output logic              rename_valid_o,
  output commit_rename_t    rename_o,
  output logic              flag_valid_o,
  output flag_update_t      flag_o
);

  typedef enum logic {RUN, FLUSH} state_e;

  state_e state_q;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_q <= RUN;
    else if (state_q == RUN && mispredict_i)
      state_q <= FLUSH;
    else
      state_q <= RUN;
  end

  // one enable drives every commit message
  assign commit_en_o = (state_q == RUN) && head_i.wb && !mispredict_i;
  assign flush_o = (state_q == FLUSH);
  assign credit_o = commit_en_o;

  assign sb_valid_o = commit_en_o && head_i.is_store;
  assign phys_free_valid_o = commit_en_o && head_i.w_v && !head_i.is_store;
  assign phys_free_reg_o = head_i.freed_reg;

  assign rename_valid_o = commit_en_o;
  assign rename_o.w_v = head_i.w_v;
  assign rename_o.alloc_reg = head_i.alloc_reg;
  assign rename_o.freed_reg = head_i.freed_reg;

  assign flag_valid_o = commit_en_o && (|head_i.flag_mask);
  assign flag_o.mask = head_i.flag_mask;
  assign flag_o.flags = head_i.flags;

  // one flush cycle empties the buffer, so no second flush can follow
  a_flush_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    state_q == FLUSH |=> !head_i.wb);

endmodule

/* src/branch_resolver.sv */
`timescale 1ns/1ps

module branch_resolver import rob_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  rob_entry_t           head_i,
  input  logic                 commit_i,
  input  logic                 flush_i,
  input  logic [NUM_FLAGS-1:0] flags_i,
  output logic                 mispredict_o,
  output logic [WORD_W-1:0]    redirect_pc_o
);

  logic              n_f, z_f, c_f, v_f;
  logic              taken;
  logic [WORD_W-1:0] next_pc;
  logic [WORD_W-1:0] predicted_pc_q;
  logic              prev_spec_q;

  assign n_f = flags_i[n_idx];
  assign z_f = flags_i[z_idx];
  assign c_f = flags_i[c_idx];
  assign v_f = flags_i[v_idx];

  always_comb
  begin
    case (head_i.bcc_op)
      EQ: taken = z_f;
      NE: taken = ~z_f;
      CS: taken = c_f;
      CC: taken = ~c_f;
      MI: taken = n_f;
      PL: taken = ~n_f;
      VS: taken = v_f;
      VC: taken = ~v_f;
      HI: taken = c_f & ~z_f;
      LS: taken = ~c_f | z_f;
      GE: taken = (n_f == v_f);
      LT: taken = (n_f != v_f);
      GT: taken = ~z_f & (n_f == v_f);
      LE: taken = z_f | (n_f != v_f);
      AL: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // register-target branches always go to resolved_pc
  assign next_pc = (head_i.is_cond_branch && !taken) ? head_i.pc + WORD_W'(4)
                                                     : head_i.resolved_pc;

  always_ff @(posedge clk_i)
  begin
    if (reset_i || flush_i)
    begin
      predicted_pc_q <= '0;
      prev_spec_q <= 1'b0;
    end
    else if (commit_i)
    begin
      predicted_pc_q <= next_pc;
      prev_spec_q <= head_i.is_spec;
    end
  end

  // masked in the flush cycle so the redirect is a single pulse
  assign mispredict_o = head_i.wb && prev_spec_q && !flush_i &&
                        (head_i.pc != predicted_pc_q);
  assign redirect_pc_o = predicted_pc_q;

endmodule

/* src/rob_pointers.sv */
`timescale 1ns/1ps

module rob_pointers
#(
  parameter int ROB_ENTRY = 8,
  localparam int TAG_W = $clog2(ROB_ENTRY)
)
(
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             alloc_i,
  input  logic             commit_i,
  input  logic             flush_i,
  output logic [TAG_W-1:0] alloc_ptr_o,
  output logic [TAG_W-1:0] commit_ptr_o
);

  logic [TAG_W:0] count_q;

  function automatic logic [TAG_W-1:0] wrap_inc(input logic [TAG_W-1:0] ptr);
    if (ptr == TAG_W'(ROB_ENTRY - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i)
  begin
    if (reset_i || flush_i)
    begin
      alloc_ptr_o <= '0;
      commit_ptr_o <= '0;
      count_q <= '0;
    end
    else
    begin
      if (alloc_i)
        alloc_ptr_o <= wrap_inc(alloc_ptr_o);
      if (commit_i)
        commit_ptr_o <= wrap_inc(commit_ptr_o);
      // occupancy moves only when exactly one side is active
      if (alloc_i && !commit_i)
        count_q <= count_q + 1'b1;
      else if (commit_i && !alloc_i)
        count_q <= count_q - 1'b1;
    end
  end

  // sender ran out of credits
  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    !(alloc_i && count_q == (TAG_W + 1)'(ROB_ENTRY)));

  a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
    !(commit_i && count_q == '0));

  // issue is not allowed while the buffer is being flushed
  a_no_issue_in_flush: assert property (@(posedge clk_i) disable iff (reset_i)
    !(alloc_i && flush_i));

endmodule

/* src/rob_entry_store.sv */
`timescale 1ns/1ps

module rob_entry_store import rob_pkg::*;
#(
  parameter int ROB_ENTRY = 8,
  parameter int NUM_FU = 3,
  localparam int TAG_W = $clog2(ROB_ENTRY)
)
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         issue_we_i,
  input  issue_entry_t issue_entry_i,
  input  logic [TAG_W-1:0] alloc_ptr_i,
  input  cdb_t         cdb_i [NUM_FU],
  input  logic         commit_en_i,
  input  logic [TAG_W-1:0] commit_ptr_i,
  input  logic         flush_i,
  output rob_entry_t   head_o
);

  // written-back bits are the only control state per entry
  logic [ROB_ENTRY-1:0] wb_q;
  issue_entry_t         info_q [ROB_ENTRY];
  logic [NUM_FLAGS-1:0] flags_q [ROB_ENTRY];
  logic [WORD_W-1:0]    rpc_q [ROB_ENTRY];

  logic [ROB_ENTRY-1:0] hit;
  logic [NUM_FLAGS-1:0] hit_flags [ROB_ENTRY];
  logic [WORD_W-1:0]    hit_result [ROB_ENTRY];

  // match every bus slot against every pending entry
  always_comb
  begin
    for (int i = 0; i < ROB_ENTRY; i++)
    begin
      hit[i] = 1'b0;
      hit_flags[i] = '0;
      hit_result[i] = '0;
      for (int j = 0; j < NUM_FU; j++)
      begin
        if (!wb_q[i] && cdb_i[j].valid && cdb_i[j].rob_tag == CDB_TAG_W'(i))
        begin
          hit[i] = 1'b1;
          hit_flags[i] = cdb_i[j].flags;
          hit_result[i] = cdb_i[j].result;
        end
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i || flush_i)
    begin
      wb_q <= '0;
    end
    else
    begin
      for (int i = 0; i < ROB_ENTRY; i++)
      begin
        if (hit[i])
          wb_q[i] <= 1'b1;
      end
      // head leaves, slot becomes free again
      if (commit_en_i)
        wb_q[commit_ptr_i] <= 1'b0;
      if (issue_we_i)
        wb_q[alloc_ptr_i] <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (issue_we_i)
      info_q[alloc_ptr_i] <= issue_entry_i;
    for (int i = 0; i < ROB_ENTRY; i++)
    begin
      if (hit[i])
      begin
        flags_q[i] <= hit_flags[i];
        // branch target arrives on the result field
        if (info_q[i].is_spec)
          rpc_q[i] <= hit_result[i];
      end
    end
  end

  always_comb
  begin
    head_o.wb = wb_q[commit_ptr_i];
    head_o.pc = info_q[commit_ptr_i].pc;
    head_o.is_store = info_q[commit_ptr_i].is_store;
    head_o.w_v = info_q[commit_ptr_i].w_v;
    head_o.alloc_reg = info_q[commit_ptr_i].alloc_reg;
    head_o.freed_reg = info_q[commit_ptr_i].freed_reg;
    head_o.is_spec = info_q[commit_ptr_i].is_spec;
    head_o.is_cond_branch = info_q[commit_ptr_i].is_cond_branch;
    head_o.bcc_op = info_q[commit_ptr_i].bcc_op;
    head_o.flag_mask = info_q[commit_ptr_i].flag_mask;
    head_o.flags = flags_q[commit_ptr_i];
    head_o.resolved_pc = rpc_q[commit_ptr_i];
  end

  // functional units never complete the same tag together
  for (genvar a = 0; a < NUM_FU; a++)
  begin : g_tag_a
    for (genvar b = a + 1; b < NUM_FU; b++)
    begin : g_tag_b
      a_unique_tag: assert property (@(posedge clk_i) disable iff (reset_i)
        !(cdb_i[a].valid && cdb_i[b].valid && cdb_i[a].rob_tag == cdb_i[b].rob_tag));
    end
  end

endmodule

/* src/rob_pkg.sv */
package rob_pkg;

  // datapath and PC width
  localparam int WORD_W = 32;
  // 64 physical registers
  localparam int PREG_W = 6;
  // tag field on the bus, wide enough for up to 16 entries
  localparam int CDB_TAG_W = 4;

  localparam int NUM_FLAGS = 4;
  // bit positions inside a flags word
  localparam int n_idx = 3;
  localparam int z_idx = 2;
  localparam int c_idx = 1;
  localparam int v_idx = 0;

  // Bcc conditions, NV is the spare code and never taken
  typedef enum logic [3:0] {
    EQ = 4'h0,
    NE = 4'h1,
    CS = 4'h2,
    CC = 4'h3,
    MI = 4'h4,
    PL = 4'h5,
    VS = 4'h6,
    VC = 4'h7,
    HI = 4'h8,
    LS = 4'h9,
    GE = 4'ha,
    LT = 4'hb,
    GT = 4'hc,
    LE = 4'hd,
    AL = 4'he,
    NV = 4'hf
  } cond_e;

  typedef struct packed {
    logic                 wb;
    logic [WORD_W-1:0]    pc;
    logic                 is_store;
    logic                 w_v;
    logic [PREG_W-1:0]    alloc_reg;
    logic [PREG_W-1:0]    freed_reg;
    logic                 is_spec;
    logic                 is_cond_branch;
    cond_e                bcc_op;
    logic [NUM_FLAGS-1:0] flag_mask;
    logic [NUM_FLAGS-1:0] flags;
    logic [WORD_W-1:0]    resolved_pc;
  } rob_entry_t;

  // fields known at issue time
  typedef struct packed {
    logic [WORD_W-1:0]    pc;
    logic                 is_store;
    logic                 w_v;
    logic [PREG_W-1:0]    alloc_reg;
    logic [PREG_W-1:0]    freed_reg;
    logic                 is_spec;
    logic                 is_cond_branch;
    cond_e                bcc_op;
    logic [NUM_FLAGS-1:0] flag_mask;
  } issue_entry_t;

  // for a speculative branch result holds the target
  typedef struct packed {
    logic                 valid;
    logic [CDB_TAG_W-1:0] rob_tag;
    logic [NUM_FLAGS-1:0] flags;
    logic [WORD_W-1:0]    result;
  } cdb_t;

  typedef struct packed {
    logic              w_v;
    logic [PREG_W-1:0] alloc_reg;
    logic [PREG_W-1:0] freed_reg;
  } commit_rename_t;

  typedef struct packed {
    logic [NUM_FLAGS-1:0] mask;
    logic [NUM_FLAGS-1:0] flags;
  } flag_update_t;

endpackage
